// ==== aggregator.sv ====
`timescale 1ns/1ps

module aggregator
  import gat_dims_pkg::*;
  import gat_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      cf_valid_i,
  output logic      cf_ready_o,
  input  coef_t     cf_coef_i,
  input  wh_vec_t   cf_wh_i,
  input  logic      cf_last_i,
  output logic      feat_req_o,
  input  logic      feat_ack_i,
  output feat_vec_t feat_o
);

  out_state_t state;
  acc_t       acc_q   [NUM_FEAT_OUT];
  acc_t       acc_nxt [NUM_FEAT_OUT];
  logic       take;

  // No intake while a finished vector is being handed out
  assign cf_ready_o = (state == OUT_ACCUM);
  assign feat_req_o = (state == OUT_REQ_HIGH);
  assign take       = cf_valid_i && cf_ready_o;

  always_comb begin
    for (int o = 0; o < NUM_FEAT_OUT; o++) begin
      acc_nxt[o] = acc_q[o] + $signed(cf_coef_i) * $signed(cf_wh_i[o]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= OUT_ACCUM;
      for (int o = 0; o < NUM_FEAT_OUT; o++) begin
        acc_q[o] <= '0;
      end
    end else begin
      case (state)
        OUT_ACCUM: begin
          if (take) begin
            for (int o = 0; o < NUM_FEAT_OUT; o++) begin
              acc_q[o] <= cf_last_i ? '0 : acc_nxt[o];
            end
            if (cf_last_i) begin
              state <= OUT_REQ_HIGH;
            end
          end
        end
        OUT_REQ_HIGH: begin
          if (feat_ack_i) begin
            state <= OUT_ACK_LOW;
          end
        end
        OUT_ACK_LOW: begin
          if (!feat_ack_i) begin
            state <= OUT_ACCUM;
          end
        end
        default: state <= OUT_ACCUM;
      endcase
    end
  end

  // Result held stable through the whole output handshake
  always_ff @(posedge clk) begin
    if (take && cf_last_i) begin
      for (int o = 0; o < NUM_FEAT_OUT; o++) begin
        feat_o[o] <= acc_nxt[o];
      end
    end
  end

endmodule

// ==== coef_unit.sv ====
`timescale 1ns/1ps

module coef_unit
  import gat_dims_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    wh_valid_i,
  output logic    wh_ready_o,
  input  wh_vec_t wh_vec_i,
  input  logic    wh_first_i,
  input  logic    wh_last_i,
  input  a_vec_t  a_vec_i,
  output logic    cf_valid_o,
  input  logic    cf_ready_i,
  output coef_t   cf_coef_o,
  output wh_vec_t cf_wh_o,
  output logic    cf_last_o
);

  score_t tgt_dot;
  score_t nbr_dot;
  score_t tgt_held;
  score_t score;
  score_t leaky;
  logic   take;

  function automatic coef_t sat_coef(input score_t v);
    score_t hi;
    score_t lo;
    hi = score_t'(2 ** (COEF_W - 1) - 1);
    lo = -score_t'(2 ** (COEF_W - 1));
    if (v > hi) begin
      return coef_t'(hi);
    end else if (v < lo) begin
      return coef_t'(lo);
    end
    return coef_t'(v);
  endfunction

  // Stage is full until downstream takes it
  assign wh_ready_o = !cf_valid_o || cf_ready_i;
  assign take       = wh_valid_i && wh_ready_o;

  always_comb begin
    tgt_dot = '0;
    nbr_dot = '0;
    for (int k = 0; k < NUM_FEAT_OUT; k++) begin
      tgt_dot = tgt_dot + $signed(wh_vec_i[k]) * $signed(a_vec_i[k]);
      nbr_dot = nbr_dot + $signed(wh_vec_i[k]) * $signed(a_vec_i[NUM_FEAT_OUT + k]);
    end
  end

  // Target node scores against itself before its product is stored
  assign score = (wh_first_i ? tgt_dot : tgt_held) + nbr_dot;

  // LeakyReLU folded into the output shift
  assign leaky = score[SCORE_W-1] ? (score >>> (COEF_SHIFT + LEAK_SHIFT))
                                  : (score >>> COEF_SHIFT);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cf_valid_o <= 1'b0;
    end else if (take) begin
      cf_valid_o <= 1'b1;
    end else if (cf_ready_i) begin
      cf_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      cf_coef_o <= sat_coef(leaky);
      cf_wh_o   <= wh_vec_i;
      cf_last_o <= wh_last_i;
      if (wh_first_i) begin
        tgt_held <= tgt_dot;
      end
    end
  end

endmodule

// ==== gat_conv.f ====
gat_dims_pkg.sv
gat_ctrl_pkg.sv
gat_param_store.sv
wh_engine.sv
coef_unit.sv
aggregator.sv
gat_conv.sv
tb_gat_conv.sv

// ==== gat_conv.sv ====
`timescale 1ns/1ps

module gat_conv
  import gat_dims_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        wgt_we_i,
  input  param_addr_t wgt_addr_i,
  input  data_t       wgt_data_i,
  input  logic        node_req_i,
  input  h_vec_t      node_feat_i,
  input  logic        node_last_i,
  output logic        node_ack_o,
  output logic        feat_req_o,
  input  logic        feat_ack_i,
  output feat_vec_t   feat_o
);

  w_mat_t  w_mat;
  a_vec_t  a_vec;

  logic    wh_valid;
  logic    wh_ready;
  wh_vec_t wh_vec;
  logic    wh_first;
  logic    wh_last;

  logic    cf_valid;
  logic    cf_ready;
  coef_t   cf_coef;
  wh_vec_t cf_wh;
  logic    cf_last;

  gat_param_store u_param_store (
    .clk        (clk),
    .rst_n      (rst_n),
    .wgt_we_i   (wgt_we_i),
    .wgt_addr_i (wgt_addr_i),
    .wgt_data_i (wgt_data_i),
    .w_mat_o    (w_mat),
    .a_vec_o    (a_vec)
  );

  wh_engine u_wh_engine (
    .clk         (clk),
    .rst_n       (rst_n),
    .node_req_i  (node_req_i),
    .node_feat_i (node_feat_i),
    .node_last_i (node_last_i),
    .node_ack_o  (node_ack_o),
    .w_mat_i     (w_mat),
    .wh_valid_o  (wh_valid),
    .wh_ready_i  (wh_ready),
    .wh_vec_o    (wh_vec),
    .wh_first_o  (wh_first),
    .wh_last_o   (wh_last)
  );

  coef_unit u_coef_unit (
    .clk        (clk),
    .rst_n      (rst_n),
    .wh_valid_i (wh_valid),
    .wh_ready_o (wh_ready),
    .wh_vec_i   (wh_vec),
    .wh_first_i (wh_first),
    .wh_last_i  (wh_last),
    .a_vec_i    (a_vec),
    .cf_valid_o (cf_valid),
    .cf_ready_i (cf_ready),
    .cf_coef_o  (cf_coef),
    .cf_wh_o    (cf_wh),
    .cf_last_o  (cf_last)
  );

  aggregator u_aggregator (
    .clk        (clk),
    .rst_n      (rst_n),
    .cf_valid_i (cf_valid),
    .cf_ready_o (cf_ready),
    .cf_coef_i  (cf_coef),
    .cf_wh_i    (cf_wh),
    .cf_last_i  (cf_last),
    .feat_req_o (feat_req_o),
    .feat_ack_i (feat_ack_i),
    .feat_o     (feat_o)
  );

endmodule

// ==== gat_ctrl_pkg.sv ====
package gat_ctrl_pkg;

  // Node intake handshake
  typedef enum logic [1:0] {
    IN_IDLE,
    IN_COMPUTE,
    IN_ACK_WAIT
  } intake_state_t;

  // Feature output handshake
  typedef enum logic [1:0] {
    OUT_ACCUM,
    OUT_REQ_HIGH,
    OUT_ACK_LOW
  } out_state_t;

endpackage

// ==== gat_dims_pkg.sv ====
package gat_dims_pkg;

  // Layer sizes
  localparam int NUM_FEAT_IN  = 4;
  localparam int NUM_FEAT_OUT = 4;
  localparam int IN_IDX_W     = $clog2(NUM_FEAT_IN);
  localparam int A_LEN        = 2 * NUM_FEAT_OUT;

  // Datapath widths
  localparam int DATA_W  = 8;
  localparam int WH_W    = 12;
  localparam int SCORE_W = 24;
  localparam int COEF_W  = 8;
  localparam int ACC_W   = 32;

  // Score to coefficient scaling
  localparam int COEF_SHIFT = 4;
  localparam int LEAK_SHIFT = 2;

  // Parameter map, W first and then a
  localparam int A_BASE       = 16;
  localparam int PARAM_DEPTH  = 24;
  localparam int PARAM_ADDR_W = $clog2(PARAM_DEPTH);

  typedef logic signed [DATA_W-1:0]  data_t;
  typedef logic signed [WH_W-1:0]    wh_t;
  typedef logic signed [SCORE_W-1:0] score_t;
  typedef logic signed [COEF_W-1:0]  coef_t;
  typedef logic signed [ACC_W-1:0]   acc_t;
  typedef logic [PARAM_ADDR_W-1:0]   param_addr_t;

  typedef data_t [NUM_FEAT_IN-1:0]  h_vec_t;
  typedef wh_t   [NUM_FEAT_OUT-1:0] wh_vec_t;
  typedef acc_t  [NUM_FEAT_OUT-1:0] feat_vec_t;
  typedef data_t [A_LEN-1:0]        a_vec_t;

  // Indexed as [output][input]
  typedef data_t [NUM_FEAT_OUT-1:0][NUM_FEAT_IN-1:0] w_mat_t;

endpackage

// ==== gat_param_store.sv ====
`timescale 1ns/1ps

module gat_param_store
  import gat_dims_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        wgt_we_i,
  input  param_addr_t wgt_addr_i,
  input  data_t       wgt_data_i,
  output w_mat_t      w_mat_o,
  output a_vec_t      a_vec_o
);

  logic wr_ok;

  // Writes past the end of the map are dropped
  assign wr_ok = wgt_we_i && (wgt_addr_i < param_addr_t'(PARAM_DEPTH));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      w_mat_o <= '0;
    end else if (wr_ok) begin
      for (int o = 0; o < NUM_FEAT_OUT; o++) begin
        for (int i = 0; i < NUM_FEAT_IN; i++) begin
          if (wgt_addr_i == param_addr_t'(o * NUM_FEAT_IN + i)) begin
            w_mat_o[o][i] <= wgt_data_i;
          end
        end
      end
    end
  end

  // Attention vector, target half in the low entries
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a_vec_o <= '0;
    end else if (wr_ok) begin
      for (int k = 0; k < A_LEN; k++) begin
        if (wgt_addr_i == param_addr_t'(A_BASE + k)) begin
          a_vec_o[k] <= wgt_data_i;
        end
      end
    end
  end

endmodule

// ==== gat_stim.txt ====
# Records: T name | W addr data | N h0 h1 h2 h3 last | E f0 f1 f2 f3
# Signed decimal, vectors listed from index 0 upwards
T single_node
W 0 2
W 5 1
W 10 3
W 15 -1
W 16 4
W 21 8
N 10 5 2 3 1
E 140 35 42 -21
T four_nodes
N 8 4 0 2 0
N 1 10 0 0 0
N 0 -6 5 0 0
N 3 2 1 4 1
E 144 118 30 -32
T leaky
N 1 0 0 0 0
N 0 -100 0 0 0
N 0 -3 0 0 1
E 0 1303 0 0
T saturate
W 0 127
W 1 127
W 5 1
W 10 0
W 15 0
W 16 2
W 20 1
W 21 0
N 127 127 0 0 0
N -128 -128 0 0 1
E -127 -127 0 0
T next_graph
N 1 2 0 0 0
N 0 -10 0 0 1
E 37211 222 0 0

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f gat_conv.f --top-module tb_gat_conv -o tb_gat_conv_sim

./obj_dir/tb_gat_conv_sim 2>&1 | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
  echo "Simulation reported failures, see sim.log"
  exit 1
fi
echo "Simulation finished without failures"

// ==== tb_gat_conv.sv ====
`timescale 1ns/1ps

module tb_gat_conv
  import gat_dims_pkg::*;
();

  typedef struct packed {
    logic        is_node;
    param_addr_t addr;
    data_t       data;
    h_vec_t      feat;
    logic        last;
  } op_t;

  logic        clk;
  logic        rst_n;
  logic        wgt_we_i;
  param_addr_t wgt_addr_i;
  data_t       wgt_data_i;
  logic        node_req_i;
  h_vec_t      node_feat_i;
  logic        node_last_i;
  logic        node_ack_o;
  logic        feat_req_o;
  logic        feat_ack_i;
  feat_vec_t   feat_o;

  op_t       op_q[$];
  feat_vec_t exp_q[$];
  string     name_q[$];
  int        num_nodes;
  int        graphs_sent;
  int        graphs_done;
  logic      node_req_q;
  logic      node_ack_q;
  logic      feat_req_q;
  logic      feat_ack_q;

  gat_conv UUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .wgt_we_i    (wgt_we_i),
    .wgt_addr_i  (wgt_addr_i),
    .wgt_data_i  (wgt_data_i),
    .node_req_i  (node_req_i),
    .node_feat_i (node_feat_i),
    .node_last_i (node_last_i),
    .node_ack_o  (node_ack_o),
    .feat_req_o  (feat_req_o),
    .feat_ack_i  (feat_ack_i),
    .feat_o      (feat_o)
  );

  always #20 clk = ~clk;

  task automatic tick();
    @(posedge clk);
    #2;
  endtask

  task automatic load_stim();
    int        fd;
    int        code;
    int        v[5];
    string     kind;
    string     line;
    string     cur_name;
    op_t       op;
    feat_vec_t want;
    fd = $fopen("gat_stim.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file gat_stim.txt");
      $display("SOME TESTS FAILED");
      $fatal(1);
    end else begin
      cur_name = "unnamed";
      while (!$feof(fd)) begin
        code = $fscanf(fd, "%s", kind);
        if (code != 1) begin
          kind = "";
        end
        if (kind == "T") begin
          code = $fscanf(fd, "%s", cur_name);
        end else if (kind == "W") begin
          code = $fscanf(fd, "%d %d", v[0], v[1]);
          op      = '0;
          op.addr = param_addr_t'(v[0]);
          op.data = data_t'(v[1]);
          op_q.push_back(op);
        end else if (kind == "N") begin
          code = $fscanf(fd, "%d %d %d %d %d", v[0], v[1], v[2], v[3], v[4]);
          op         = '0;
          op.is_node = 1'b1;
          for (int i = 0; i < NUM_FEAT_IN; i++) begin
            op.feat[i] = data_t'(v[i]);
          end
          op.last = (v[4] != 0);
          op_q.push_back(op);
          num_nodes++;
        end else if (kind == "E") begin
          code = $fscanf(fd, "%d %d %d %d", v[0], v[1], v[2], v[3]);
          for (int o = 0; o < NUM_FEAT_OUT; o++) begin
            want[o] = acc_t'(v[o]);
          end
          exp_q.push_back(want);
          name_q.push_back(cur_name);
        end else if (kind != "") begin
          // Anything else is a comment up to the end of the line
          void'($fgets(line, fd));
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic check_feat(input string name, input feat_vec_t want, input feat_vec_t got);
    int bad;
    bad = -1;
    for (int o = NUM_FEAT_OUT - 1; o >= 0; o--) begin
      if (got[o] !== want[o]) begin
        bad = o;
      end
    end
    if (bad >= 0) begin
      $display("FAILED %s word %0d expected %0d actual %0d",
               name, bad, $signed(want[bad]), $signed(got[bad]));
      $display("SOME TESTS FAILED");
      $fatal(1);
    end
  endtask

  task automatic report_protocol_error(input string what);
    $display("Handshake order broken at %0t ns: %s", $time, what);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic write_param(input op_t op);
    tick();
    wgt_we_i   = 1'b1;
    wgt_addr_i = op.addr;
    wgt_data_i = op.data;
    tick();
    wgt_we_i = 1'b0;
  endtask

  // Full four-phase cycle on the node intake
  task automatic send_node(input op_t op);
    tick();
    node_feat_i = op.feat;
    node_last_i = op.last;
    node_req_i  = 1'b1;
    do tick(); while (!node_ack_o);
    // Req stays up past the ack, ack must not drop meanwhile
    repeat (2) tick();
    node_req_i = 1'b0;
    do tick(); while (node_ack_o);
  endtask

  task automatic run_ops();
    foreach (op_q[n]) begin
      if (op_q[n].is_node) begin
        send_node(op_q[n]);
        if (op_q[n].last) begin
          graphs_sent++;
        end
      end else begin
        // Reload only once every subgraph sent so far has come out
        while (graphs_done != graphs_sent) begin
          tick();
        end
        write_param(op_q[n]);
      end
    end
  endtask

  task automatic collect_outputs();
    int delay;
    for (int n = 0; n < exp_q.size(); n++) begin
      do tick(); while (!feat_req_o);
      check_feat(name_q[n], exp_q[n], feat_o);
      delay = $urandom % 6;
      repeat (delay) tick();
      feat_ack_i = 1'b1;
      do tick(); while (feat_req_o);
      delay = $urandom % 6;
      repeat (delay) tick();
      feat_ack_i = 1'b0;
      graphs_done++;
    end
  endtask

  task automatic watchdog(input int cycles);
    repeat (cycles) @(posedge clk);
    $display("Timeout after %0d cycles, the feature output handshake never completed", cycles);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  // Four-phase order on both streams, sampled away from the edges
  always @(negedge clk) begin
    if (rst_n) begin
      if (node_ack_o && !node_ack_q && !node_req_q) begin
        report_protocol_error("node_ack_o rose while node_req_i was low");
      end
      if (!node_ack_o && node_ack_q && node_req_q) begin
        report_protocol_error("node_ack_o fell while node_req_i was still high");
      end
      if (!feat_req_o && feat_req_q && !feat_ack_q) begin
        report_protocol_error("feat_req_o fell before feat_ack_i was raised");
      end
    end
    node_req_q = node_req_i;
    node_ack_q = node_ack_o;
    feat_req_q = feat_req_o;
    feat_ack_q = feat_ack_i;
  end

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    wgt_we_i    = 1'b0;
    wgt_addr_i  = '0;
    wgt_data_i  = '0;
    node_req_i  = 1'b0;
    node_feat_i = '0;
    node_last_i = 1'b0;
    feat_ack_i  = 1'b0;
    num_nodes   = 0;
    graphs_sent = 0;
    graphs_done = 0;
    void'($urandom(28577));
    load_stim();
    fork
      watchdog(200 * num_nodes + 1000);
    join_none
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    fork
      run_ops();
      collect_outputs();
    join
    if (exp_q.size() > 0 && graphs_sent == exp_q.size()) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      $display("Subgraph count mismatch: %0d sent, %0d expected",
               graphs_sent, exp_q.size());
      $display("SOME TESTS FAILED");
      $fatal(1);
    end
  end

endmodule

// ==== wh_engine.sv ====
`timescale 1ns/1ps

module wh_engine
  import gat_dims_pkg::*;
  import gat_ctrl_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    node_req_i,
  input  h_vec_t  node_feat_i,
  input  logic    node_last_i,
  output logic    node_ack_o,
  input  w_mat_t  w_mat_i,
  output logic    wh_valid_o,
  input  logic    wh_ready_i,
  output wh_vec_t wh_vec_o,
  output logic    wh_first_o,
  output logic    wh_last_o
);

  intake_state_t       state;
  h_vec_t              h_q;
  logic [IN_IDX_W-1:0] in_idx;
  score_t              mac_q   [NUM_FEAT_OUT];
  score_t              mac_nxt [NUM_FEAT_OUT];
  logic                first_pending;
  logic                capture;
  logic                last_step;
  logic                handoff;

  function automatic wh_t sat_wh(input score_t v);
    score_t hi;
    score_t lo;
    hi = score_t'(2 ** (WH_W - 1) - 1);
    lo = -score_t'(2 ** (WH_W - 1));
    if (v > hi) begin
      return wh_t'(hi);
    end else if (v < lo) begin
      return wh_t'(lo);
    end
    return wh_t'(v);
  endfunction

  assign capture   = (state == IN_IDLE) && node_req_i;
  assign last_step = (state == IN_COMPUTE) && (in_idx == IN_IDX_W'(NUM_FEAT_IN - 1));
  assign handoff   = wh_valid_o && wh_ready_i;

  // One input feature against one column of W per cycle
  always_comb begin
    for (int o = 0; o < NUM_FEAT_OUT; o++) begin
      mac_nxt[o] = mac_q[o] + $signed(h_q[in_idx]) * $signed(w_mat_i[o][in_idx]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state         <= IN_IDLE;
      node_ack_o    <= 1'b0;
      wh_valid_o    <= 1'b0;
      in_idx        <= '0;
      first_pending <= 1'b1;
    end else begin
      if (handoff) begin
        wh_valid_o <= 1'b0;
      end
      // Host dropped req, close the four-phase cycle
      if (node_ack_o && !node_req_i) begin
        node_ack_o <= 1'b0;
      end
      case (state)
        IN_IDLE: begin
          if (node_req_i) begin
            node_ack_o    <= 1'b1;
            in_idx        <= '0;
            first_pending <= node_last_i;
            state         <= IN_COMPUTE;
          end
        end
        IN_COMPUTE: begin
          in_idx <= in_idx + 1'b1;
          if (last_step) begin
            wh_valid_o <= 1'b1;
            state      <= IN_ACK_WAIT;
          end
        end
        IN_ACK_WAIT: begin
          // Needs ack low and the result taken downstream
          if (!node_ack_o && (!wh_valid_o || handoff)) begin
            state <= IN_IDLE;
          end
        end
        default: state <= IN_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      h_q        <= node_feat_i;
      wh_first_o <= first_pending;
      wh_last_o  <= node_last_i;
      for (int o = 0; o < NUM_FEAT_OUT; o++) begin
        mac_q[o] <= '0;
      end
    end else if (state == IN_COMPUTE) begin
      for (int o = 0; o < NUM_FEAT_OUT; o++) begin
        mac_q[o] <= mac_nxt[o];
      end
      if (last_step) begin
        for (int o = 0; o < NUM_FEAT_OUT; o++) begin
          wh_vec_o[o] <= sat_wh(mac_nxt[o]);
        end
      end
    end
  end

endmodule
